// File: Bender.yml
package:
  name: cache_controller

sources:
  - files:
      - source/cache_pkg.sv
      - source/l1_direct_cache.sv
      - source/l2_way.sv
      - source/l2_lru_select.sv
      - source/main_memory_model.sv
      - source/cache_sequencer.sv
      - source/cache_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_cache_top.sv

// File: all.f
source/cache_pkg.sv
source/l1_direct_cache.sv
source/l2_way.sv
source/l2_lru_select.sv
source/main_memory_model.sv
source/cache_sequencer.sv
source/cache_top.sv
verif/tb_clock_gen.sv
verif/tb_cache_top.sv

// File: source/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_BITS   = 32;                                 // request address width
    localparam int BYTE_BITS   = 8;                                  // one data byte
    localparam int BLOCK_BYTES = 4;                                  // bytes in every block
    localparam int MEM_BLOCKS  = 1024;                               // blocks held by main memory
    localparam int L1_LINES    = 32;                                 // one block per L1 line
    localparam int L2_SETS     = 128;
    localparam int L2_WAYS     = 4;
    localparam int L2_LATENCY  = 3;                                  // capture edge to L2 completion
    localparam int MEM_LATENCY = 13;                                 // capture edge to memory completion

    typedef logic [ADDR_BITS-1:0]                       addr_t;
    typedef logic [BYTE_BITS-1:0]                       byte_t;
    typedef logic [BLOCK_BYTES*BYTE_BITS-1:0]           block_t;
    typedef logic [$clog2(MEM_BLOCKS)-1:0]              blk_id_t;    // address without offset, wraps at 1024
    typedef logic [$clog2(BLOCK_BYTES)-1:0]             offset_t;
    typedef logic [$clog2(L1_LINES)-1:0]                l1_index_t;
    typedef logic [$bits(blk_id_t)-$bits(l1_index_t)-1:0] l1_tag_t;
    typedef logic [$clog2(L2_SETS)-1:0]                 l2_index_t;
    typedef logic [$bits(blk_id_t)-$bits(l2_index_t)-1:0] l2_tag_t;
    typedef logic [$clog2(L2_WAYS)-1:0]                 way_t;
    typedef logic [$clog2(L2_WAYS)-1:0]                 lru_rank_t;  // 0 is least recent, 3 most recent

    // way n starts at rank n in every set
    localparam lru_rank_t [L2_WAYS-1:0] LRU_RESET = {lru_rank_t'(3), lru_rank_t'(2),
                                                     lru_rank_t'(1), lru_rank_t'(0)};

    typedef struct packed {
        addr_t address;
        byte_t wdata;                                                // only meaningful for writes
        logic  write;                                                // 1 for a write, 0 for a read
    } cache_req_t;

    typedef struct packed {
        blk_id_t   blk_id;
        offset_t   offset;
        l1_index_t l1_index;
        l1_tag_t   l1_tag;
        l2_index_t l2_index;
        l2_tag_t   l2_tag;
    } lookup_t;

    typedef enum logic [1:0] {
        S_L1,                                                        // idle or checking L1
        S_L2_WAIT,                                                   // counting down the L2 latency
        S_MEM_WAIT                                                   // counting down the memory latency
    } seq_state_e;

endpackage

// File: source/cache_sequencer.sv
`timescale 1ns/100ps

module cache_sequencer
    import cache_pkg::*;
(
    input  logic    clk_cc,
    input  logic    rst,
    input  addr_t   address,
    input  byte_t   data,
    input  logic    mode,
    input  logic    l1_hit,
    input  logic    l2_hit,
    input  block_t  l1_block,
    input  block_t  l2_block,
    input  block_t  mem_block,
    output lookup_t lkp,
    output byte_t   wdata,
    output logic    wr_strobe,                                       // byte write on all levels at completion
    output logic    l1_fill,
    output logic    l2_fill,
    output logic    lru_touch,
    output block_t  fill_block,
    output byte_t   output_data,
    output logic    hit1,
    output logic    hit2,
    output logic    busy
);

    cache_req_t req;                                                 // request held while busy is high
    logic       req_valid;                                           // req was captured at the last edge
    seq_state_e state;
    logic [3:0] lat_cnt;                                             // edges since the capture edge
    blk_id_t    blk_id;
    logic       done;                                                // the current edge completes the request
    block_t     resp_block;                                          // block the read byte comes from

    function automatic byte_t pick_byte(block_t blk, offset_t off);
        return blk[off*BYTE_BITS +: BYTE_BITS];
    endfunction

    always_comb
    begin
        blk_id       = blk_id_t'(req.address >> $bits(offset_t));    // drop the offset and wrap at 1024
        lkp.blk_id   = blk_id;
        lkp.offset   = offset_t'(req.address);
        lkp.l1_index = l1_index_t'(blk_id);
        lkp.l1_tag   = l1_tag_t'(blk_id >> $bits(l1_index_t));
        lkp.l2_index = l2_index_t'(blk_id);
        lkp.l2_tag   = l2_tag_t'(blk_id >> $bits(l2_index_t));
    end

    always_comb
    begin
        done       = 1'b0;
        fill_block = mem_block;                                      // a memory access fills both levels
        resp_block = mem_block;
        case (state)
            S_L1:       
            begin
                done       = req_valid && l1_hit;
                resp_block = l1_block;
            end
            S_L2_WAIT:  
            begin
                done       = (lat_cnt == 4'(L2_LATENCY - 1)) && l2_hit;
                fill_block = l2_block;                               // promote the L2 copy into L1
                resp_block = l2_block;
            end
            S_MEM_WAIT: done = (lat_cnt == 4'(MEM_LATENCY - 1));
            default:    done = 1'b0;
        endcase
    end

    assign wdata     = req.wdata;
    assign wr_strobe = done && req.write;                            // write-through goes out on every level
    assign l1_fill   = done && !req.write && (state != S_L1);
    assign l2_fill   = done && !req.write && (state == S_MEM_WAIT);  // victim way takes the memory block
    assign lru_touch = done && !req.write && (state != S_L1);

    always_ff @(posedge clk_cc)
    begin
        if (!busy)
        begin
            req <= '{address: address, wdata: data, write: mode};    // inputs are sampled whenever idle
        end
    end

    always_ff @(posedge clk_cc)
    begin
        if (rst)
        begin
            req_valid   <= 1'b0;
            state       <= S_L1;
            lat_cnt     <= '0;
            busy        <= 1'b0;
            hit1        <= 1'b0;
            hit2        <= 1'b0;
            output_data <= '0;
        end
        else
        begin
            req_valid <= !busy;                                      // the edge that ends a miss captures nothing
            case (state)
                S_L1:
                begin
                    if (req_valid && !l1_hit)
                    begin
                        state   <= S_L2_WAIT;                        // L1 miss shows busy one edge after capture
                        lat_cnt <= 4'd1;
                        busy    <= 1'b1;
                    end
                end
                S_L2_WAIT:
                begin
                    lat_cnt <= lat_cnt + 4'd1;
                    if (lat_cnt == 4'(L2_LATENCY - 1) && !l2_hit)
                    begin
                        state <= S_MEM_WAIT;                         // L2 miss keeps counting toward memory
                    end
                end
                default:
                begin
                    lat_cnt <= lat_cnt + 4'd1;
                end
            endcase
            if (done)
            begin
                state       <= S_L1;
                busy        <= 1'b0;
                hit1        <= (state == S_L1);
                hit2        <= (state == S_L2_WAIT);
                output_data <= req.write ? '0 : pick_byte(resp_block, lkp.offset);
            end
        end
    end

    // a request is served by exactly one level
    assert property (@(posedge clk_cc) disable iff (rst) !(hit1 && hit2));

endmodule

// File: source/cache_top.sv
`timescale 1ns/100ps

module cache_top
    import cache_pkg::*;
(
    input  logic  clk_cc,
    input  logic  rst,
    input  addr_t address,
    input  byte_t data,
    input  logic  mode,                                              // 0 reads and 1 writes
    output byte_t output_data,
    output logic  hit1,
    output logic  hit2,
    output logic  busy
);

    lookup_t              lkp;                                       // decoded request seen by every level
    byte_t                wdata;
    logic                 wr_strobe;
    logic                 l1_fill;
    logic                 l2_fill;
    logic                 lru_touch;
    block_t               fill_block;                                // block loaded into L1
    logic                 l1_hit;
    block_t               l1_block;
    logic [L2_WAYS-1:0]   way_hit;
    block_t [L2_WAYS-1:0] way_block;
    logic [L2_WAYS-1:0]   fill_en_vec;                               // one-hot on the victim during a fill
    logic                 l2_hit;
    block_t               l2_block;
    way_t                 victim;
    block_t               mem_block;

    cache_sequencer u_sequencer (
        .clk_cc(clk_cc), .rst(rst), .address(address), .data(data), .mode(mode),
        .l1_hit(l1_hit), .l2_hit(l2_hit), .l1_block(l1_block), .l2_block(l2_block),
        .mem_block(mem_block), .lkp(lkp), .wdata(wdata), .wr_strobe(wr_strobe),
        .l1_fill(l1_fill), .l2_fill(l2_fill), .lru_touch(lru_touch), .fill_block(fill_block),
        .output_data(output_data), .hit1(hit1), .hit2(hit2), .busy(busy)
    );

    l1_direct_cache u_l1 (
        .clk_cc(clk_cc), .rst(rst), .lkp(lkp), .wdata(wdata), .wr_strobe(wr_strobe),
        .l1_fill(l1_fill), .fill_block(fill_block), .l1_hit(l1_hit), .l1_block(l1_block)
    );

    for (genvar w = 0; w < L2_WAYS; w++)
    begin : g_way
        l2_way u_way (
            .clk_cc(clk_cc), .rst(rst), .lkp(lkp), .wdata(wdata), .wr_strobe(wr_strobe),
            .fill_en(fill_en_vec[w]), .fill_block(mem_block),         // ways only fill from memory
            .way_hit(way_hit[w]), .way_block(way_block[w])
        );
    end

    l2_lru_select u_lru (
        .clk_cc(clk_cc), .rst(rst), .lkp(lkp), .way_hit(way_hit), .way_block(way_block),
        .lru_touch(lru_touch), .l2_fill(l2_fill), .l2_hit(l2_hit), .l2_block(l2_block),
        .victim(victim), .fill_en_vec(fill_en_vec)
    );

    main_memory_model u_mem (
        .clk_cc(clk_cc), .lkp(lkp), .wdata(wdata), .wr_strobe(wr_strobe), .mem_block(mem_block)
    );

endmodule

// File: source/l1_direct_cache.sv
`timescale 1ns/100ps

module l1_direct_cache
    import cache_pkg::*;
(
    input  logic    clk_cc,
    input  logic    rst,
    input  lookup_t lkp,
    input  byte_t   wdata,
    input  logic    wr_strobe,
    input  logic    l1_fill,
    input  block_t  fill_block,
    output logic    l1_hit,
    output block_t  l1_block
);

    l1_tag_t             tag_q  [L1_LINES];
    block_t              data_q [L1_LINES];
    logic [L1_LINES-1:0] valid_q;                                    // all lines empty after reset

    assign l1_hit   = valid_q[lkp.l1_index] && (tag_q[lkp.l1_index] == lkp.l1_tag);
    assign l1_block = data_q[lkp.l1_index];

    always_ff @(posedge clk_cc)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (l1_fill)
        begin
            valid_q[lkp.l1_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_cc)
    begin
        if (l1_fill)
        begin
            tag_q[lkp.l1_index]  <= lkp.l1_tag;                      // the old line is simply dropped
            data_q[lkp.l1_index] <= fill_block;
        end
        else if (wr_strobe && l1_hit)
        begin
            data_q[lkp.l1_index][lkp.offset*BYTE_BITS +: BYTE_BITS] <= wdata;
        end
    end

endmodule

// File: source/l2_lru_select.sv
`timescale 1ns/100ps

module l2_lru_select
    import cache_pkg::*;
(
    input  logic                 clk_cc,
    input  logic                 rst,
    input  lookup_t              lkp,
    input  logic [L2_WAYS-1:0]   way_hit,
    input  block_t [L2_WAYS-1:0] way_block,
    input  logic                 lru_touch,
    input  logic                 l2_fill,
    output logic                 l2_hit,
    output block_t               l2_block,
    output way_t                 victim,                             // way holding rank 0 in this set
    output logic [L2_WAYS-1:0]   fill_en_vec
);

    lru_rank_t [L2_WAYS-1:0] rank_q [L2_SETS];
    lru_rank_t [L2_WAYS-1:0] cur_rank;                               // ranks of the addressed set
    way_t                    hit_way;
    way_t                    touch_way;
    logic [L2_WAYS-1:0]      rank_seen;                              // one bit per rank value present

    always_comb
    begin
        cur_rank  = rank_q[lkp.l2_index];
        hit_way   = '0;
        victim    = '0;
        rank_seen = '0;
        for (int w = 0; w < L2_WAYS; w++)
        begin
            if (way_hit[w])
            begin
                hit_way = way_t'(w);
            end
            if (cur_rank[w] == '0)
            begin
                victim = way_t'(w);
            end
            rank_seen[cur_rank[w]] = 1'b1;
        end
        for (int w = 0; w < L2_WAYS; w++)
        begin
            fill_en_vec[w] = l2_fill && (victim == way_t'(w));
        end
    end

    assign l2_hit    = |way_hit;
    assign l2_block  = way_block[hit_way];
    assign touch_way = l2_hit ? hit_way : victim;                    // a miss refreshes the freshly filled way

    always_ff @(posedge clk_cc)
    begin
        if (rst)
        begin
            for (int s = 0; s < L2_SETS; s++)
            begin
                rank_q[s] <= LRU_RESET;
            end
        end
        else if (lru_touch)
        begin
            for (int w = 0; w < L2_WAYS; w++)
            begin
                if (way_t'(w) == touch_way)
                begin
                    rank_q[lkp.l2_index][w] <= lru_rank_t'(L2_WAYS - 1);
                end
                else if (cur_rank[w] > cur_rank[touch_way])
                begin
                    rank_q[lkp.l2_index][w] <= cur_rank[w] - 1'b1;   // ways above the touched one slide down
                end
            end
        end
    end

    // a block lives in at most one way, since fills only happen after an L2 miss
    assert property (@(posedge clk_cc) disable iff (rst) $onehot0(way_hit));
    // every touch has to start from a full permutation of ranks
    assert property (@(posedge clk_cc) disable iff (rst) lru_touch |-> &rank_seen);

endmodule

// File: source/l2_way.sv
`timescale 1ns/100ps

module l2_way
    import cache_pkg::*;
(
    input  logic    clk_cc,
    input  logic    rst,
    input  lookup_t lkp,
    input  byte_t   wdata,
    input  logic    wr_strobe,
    input  logic    fill_en,                                         // this way is the victim of a fill
    input  block_t  fill_block,
    output logic    way_hit,
    output block_t  way_block
);

    l2_tag_t            tag_q  [L2_SETS];
    block_t             data_q [L2_SETS];
    logic [L2_SETS-1:0] valid_q;

    assign way_hit   = valid_q[lkp.l2_index] && (tag_q[lkp.l2_index] == lkp.l2_tag);
    assign way_block = data_q[lkp.l2_index];

    always_ff @(posedge clk_cc)
    begin
        if (rst)
        begin
            valid_q <= '0;
        end
        else if (fill_en)
        begin
            valid_q[lkp.l2_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk_cc)
    begin
        if (fill_en)
        begin
            tag_q[lkp.l2_index]  <= lkp.l2_tag;
            data_q[lkp.l2_index] <= fill_block;                      // victim is overwritten, memory is current
        end
        else if (wr_strobe && way_hit)
        begin
            data_q[lkp.l2_index][lkp.offset*BYTE_BITS +: BYTE_BITS] <= wdata;
        end
    end

endmodule

// File: source/main_memory_model.sv
`timescale 1ns/100ps

module main_memory_model
    import cache_pkg::*;
(
    input  logic    clk_cc,
    input  lookup_t lkp,
    input  byte_t   wdata,
    input  logic    wr_strobe,
    output block_t  mem_block
);

    block_t mem_q [MEM_BLOCKS];

    initial
    begin
        for (int i = 0; i < MEM_BLOCKS; i++)
        begin
            mem_q[i] = block_t'(i);                                  // each word starts as its block number
        end
    end

    assign mem_block = mem_q[lkp.blk_id];                            // latency is counted in the sequencer

    always @(posedge clk_cc)
    begin
        if (wr_strobe)
        begin
            mem_q[lkp.blk_id][lkp.offset*BYTE_BITS +: BYTE_BITS] <= wdata;
        end
    end

endmodule

// File: verif/cache_stimulus.txt
# mode(0 read, 1 write) address(hex) data(hex) level(1 L1, 2 L2, 0 memory) byte(hex)
# memory block b starts as the word b, writes expect byte 00
0 00000414 00 0 05
0 00000415 00 1 01
0 00000414 00 1 05
0 00000494 00 0 25
0 00000414 00 2 05
1 00000414 a5 1 00
0 00000414 00 1 a5
1 00000495 3c 2 00
0 00000495 00 2 3c
0 00000414 00 2 a5
1 00000aaa 7e 0 00
0 00000aaa 00 0 7e
0 00000aa8 00 1 aa
0 00000050 00 0 14
0 00000250 00 0 94
0 00000450 00 0 14
0 00000650 00 0 94
0 00000850 00 0 14
0 00000050 00 0 14
0 00000650 00 2 94
0 00000250 00 0 94
0 00000850 00 2 14
0 00000450 00 0 14

// File: verif/tb_cache_top.sv
`timescale 1ns/100ps

module tb_cache_top
    import cache_pkg::*;
();

    logic  clk_cc;
    logic  rst;
    addr_t address;
    byte_t data;
    logic  mode;
    byte_t output_data;
    logic  hit1;
    logic  hit2;
    logic  busy;

    int    error_count;                                              // mismatches and other errors
    int    test_count;
    int    fail_count;                                               // tests with at least one error

    tb_clock_gen u_clk (.clk_cc(clk_cc));

    cache_top DUT (
        .clk_cc(clk_cc), .rst(rst), .address(address), .data(data), .mode(mode),
        .output_data(output_data), .hit1(hit1), .hit2(hit2), .busy(busy)
    );

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_byte(input string name, input byte_t got, input byte_t exp);
        if (got !== exp)
        begin
            $display("Mismatch at %0t ns: %s got 0x%02h expected 0x%02h", $time, name, got, exp);
            error_count++;
        end
    endtask

    // level 1 is an L1 hit, 2 an L2 hit and 0 a memory access
    task automatic compare_level(input logic got_hit1, input logic got_hit2, input int level);
        compare_flag("hit1", got_hit1, level == 1);
        compare_flag("hit2", got_hit2, level == 2);
    endtask

    task automatic compare_latency(input int got, input int exp);
        if (got != exp)
        begin
            $display("Mismatch at %0t ns: latency got %0d expected %0d", $time, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input int num, input string what, input int errors_before);
        test_count++;
        if (error_count == errors_before)
        begin
            $display("test %0d %s: ok", num, what);
        end
        else
        begin
            fail_count++;
            $display("test %0d %s: FAILED, %0d errors", num, what, error_count - errors_before);
        end
    endtask

    task automatic drive_request(input logic wr, input addr_t addr, input byte_t wbyte);
        mode    = wr;
        address = addr;
        data    = wbyte;
    endtask

    // returns the rising edges from the capture edge to the edge where busy is low
    task automatic wait_not_busy(output int cycles, output logic timed_out);
        cycles    = 0;
        timed_out = 1'b1;
        @(posedge clk_cc);                                           // capture edge of the request
        while (timed_out && cycles < 4 * MEM_LATENCY)
        begin
            @(posedge clk_cc);
            cycles++;
            @(negedge clk_cc);                                       // registered outputs are settled
            if (!busy)
            begin
                timed_out = 1'b0;
            end
        end
    endtask

    initial
    begin
        int    fd;
        int    status;
        int    fields;
        string line;
        string what;
        logic  wr;
        addr_t addr;
        byte_t wbyte;
        int    level;
        byte_t exp_byte;
        int    exp_lat;
        int    cycles;
        logic  timed_out;
        logic  aborted;                                              // the DUT stopped answering
        int    errors_before;

        error_count = 0;
        test_count  = 0;
        fail_count  = 0;
        rst         = 1'b1;
        drive_request(1'b0, '0, '0);
        repeat (4) @(posedge clk_cc);
        @(negedge clk_cc);
        rst = 1'b0;

        errors_before = error_count;                                 // outputs right after reset
        compare_flag("busy", busy, 1'b0);
        compare_level(hit1, hit2, 0);
        compare_byte("output_data", output_data, '0);
        report_test(0, "reset state", errors_before);

        aborted = 1'b0;
        fd = $fopen("verif/cache_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("Error: the stimulus file verif/cache_stimulus.txt could not be opened");
            error_count++;
        end
        else
        begin
            while (!$feof(fd) && !aborted)
            begin
                line   = "";
                status = $fgets(line, fd);
                if (status > 1 && line[0] != "#")
                begin
                    fields = $sscanf(line, "%h %h %h %d %h", wr, addr, wbyte, level, exp_byte);
                    if (fields != 5)
                    begin
                        $display("Error: stimulus line could not be read: %s", line);
                        error_count++;
                    end
                    else
                    begin
                        drive_request(wr, addr, wbyte);              // inputs change on the falling edge
                        wait_not_busy(cycles, timed_out);
                        what = $sformatf("%s 0x%08h level %0d", wr ? "write" : "read ", addr, level);
                        errors_before = error_count;
                        if (timed_out)
                        begin
                            $display("Error at %0t ns: busy never fell after the request", $time);
                            error_count++;
                            aborted = 1'b1;                          // no later request can complete
                        end
                        else
                        begin
                            exp_lat = (level == 1) ? 1 : (level == 2) ? L2_LATENCY : MEM_LATENCY;
                            compare_level(hit1, hit2, level);
                            compare_byte("output_data", output_data, exp_byte);
                            compare_latency(cycles, exp_lat);
                        end
                        report_test(test_count, what, errors_before);
                    end
                end
            end
            $fclose(fd);
        end

        if (test_count < 2)
        begin
            $display("Error: no requests were read from the stimulus file");
            error_count++;
        end
        $display("%0d tests, %0d failed, %0d errors", test_count, fail_count, error_count);
        if (error_count == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen
(
    output logic clk_cc
);

    initial
    begin
        clk_cc = 1'b0;                                               // first rising edge at 4 ns
        forever
        begin
            #4 clk_cc = ~clk_cc;                                     // half of the 8 ns period
        end
    end

endmodule
